// File: files.f
rtl/mipsPkg.sv
rtl/alu.sv
rtl/controlDecoder.sv
rtl/registerFile.sv
rtl/dataMemory.sv
rtl/executeStage.sv
rtl/instructionFetch.sv
rtl/fetchDecodeReg.sv
rtl/mipsCore.sv
sim/mipsCoreTb.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! verilator --binary --assert -j 0 --top-module mipsCoreTb -Mdir "$buildDir" -f files.f; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/VmipsCoreTb" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if [ "$runStatus" -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -qx "Finished with no errors" "$logFile"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1

// File: sim/mipsCoreTb.sv
`timescale 1ns/10ps

module mipsCoreTb;
	import mipsPkg::*;

	localparam int imemWords = 64;
	localparam int dmemWords = 64;
	localparam int imemAddrWidth = $clog2(imemWords);
	localparam int resetCycles = 16;
	localparam int cycleLimit = 1000; // 5 tests of ~110 cycles incl. load, with margin
	localparam logic [31:0] markerAddr = 32'h0000_00FC; // End-of-program store

	logic Clk;
	logic rst;
	logic imemWriteEn;
	logic [imemAddrWidth-1:0] imemAddr;
	logic [dataWidth-1:0] imemData;
	logic regWriteEn;
	logic [regAddrWidth-1:0] regWriteAddr;
	logic [dataWidth-1:0] regWriteData;
	logic memWriteEn;
	logic [dataWidth-1:0] memAddr;
	logic [dataWidth-1:0] memWriteData;

	logic [31:0] prog [$];
	logic [4:0] wrAddrQ [$], expWrAddr [$];
	logic [31:0] wrDataQ [$], expWrData [$];
	logic [31:0] stAddrQ [$], expStAddr [$];
	logic [31:0] stDataQ [$], expStData [$];
	logic [31:0] randState = 32'd51;
	int wrBase, stBase, markerBase, resetErrBase;
	int markerCount = 0;
	int strobeInReset = 0;
	int cycleCount = 0;
	int testErrors, errorCount = 0, failedTests = 0;
	string testName;

	mipsCore #(.imemWords(imemWords), .dmemWords(dmemWords)) i_dut (
		.Clk(Clk), .rst(rst), .imemWriteEn(imemWriteEn), .imemAddr(imemAddr),
		.imemData(imemData), .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData), .memWriteEn(memWriteEn), .memAddr(memAddr),
		.memWriteData(memWriteData)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	always @(posedge Clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Finished with errors");
			$finish;
		end
	end

	// Event monitor, sampled mid-cycle
	always @(negedge Clk) begin
		if (rst) begin
			if (regWriteEn || memWriteEn)
				strobeInReset++;
		end else begin
			if (regWriteEn) begin
				wrAddrQ.push_back(regWriteAddr);
				wrDataQ.push_back(regWriteData);
			end
			if (memWriteEn) begin
				if (memAddr == markerAddr)
					markerCount++;
				else begin
					stAddrQ.push_back(memAddr);
					stDataQ.push_back(memWriteData);
				end
			end
		end
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = randState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		randState = x;
		return x;
	endfunction

	function automatic logic [15:0] randImm();
		logic [31:0] r;
		r = xorshift32();
		return r[15:0];
	endfunction

	function automatic logic [31:0] signExtend(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic [31:0] rInstr(logic [5:0] funct, int rs, int rt, int rd);
		instrT w;
		w = '0;
		w.rType.op = opRType;
		w.rType.rs = 5'(rs);
		w.rType.rt = 5'(rt);
		w.rType.rd = 5'(rd);
		w.rType.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] iInstr(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		instrT w;
		w.iType.op = op;
		w.iType.rs = 5'(rs);
		w.iType.rt = 5'(rt);
		w.iType.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] jInstr(int wordTarget);
		instrT w;
		w = '0;
		w[25:0] = 26'(wordTarget); // Word address of target
		w.rType.op = opJ;
		return w;
	endfunction

	task automatic addWritingInstr(logic [31:0] word, int rd, logic [31:0] value);
		prog.push_back(word);
		expWrAddr.push_back(5'(rd));
		expWrData.push_back(value);
	endtask

	task automatic addStoringInstr(logic [31:0] word, logic [31:0] addr, logic [31:0] data);
		prog.push_back(word);
		expStAddr.push_back(addr);
		expStData.push_back(data);
	endtask

	task automatic startTest(string name);
		testName = name;
		testErrors = 0;
		prog.delete();
		expWrAddr.delete();
		expWrData.delete();
		expStAddr.delete();
		expStData.delete();
	endtask

	task automatic loadProgram();
		int i;
		@(negedge Clk);
		rst = 1'b1;
		for (i = 0; i < imemWords; i++) begin
			imemWriteEn = 1'b1;
			imemAddr = imemAddrWidth'(i);
			imemData = nopWord; // Pad
			if (i < prog.size())
				imemData = prog[i];
			@(negedge Clk);
		end
		imemWriteEn = 1'b0;
		repeat (resetCycles) @(negedge Clk);
		wrBase = wrAddrQ.size();
		stBase = stAddrQ.size();
		markerBase = markerCount;
		rst = 1'b0;
	endtask

	task automatic executeProgram();
		prog.push_back(iInstr(opSw, 0, 0, 16'h00FC)); // Marker store
		prog.push_back(jInstr(prog.size())); // Park on self
		resetErrBase = strobeInReset;
		loadProgram();
		while (markerCount == markerBase)
			@(negedge Clk);
	endtask

	task automatic compareEvents();
		int i;
		int n;
		n = wrAddrQ.size() - wrBase;
		if (n != expWrAddr.size()) begin
			$display("Fail %s: write count expected %0d actual %0d", testName, expWrAddr.size(), n);
			testErrors++;
		end
		for (i = 0; i < n && i < expWrAddr.size(); i++) begin
			if (wrAddrQ[wrBase+i] != expWrAddr[i] || wrDataQ[wrBase+i] != expWrData[i]) begin
				$display("Fail %s: write %0d expected r%0d=%h actual r%0d=%h", testName, i,
					expWrAddr[i], expWrData[i], wrAddrQ[wrBase+i], wrDataQ[wrBase+i]);
				testErrors++;
			end
		end
		n = stAddrQ.size() - stBase;
		if (n != expStAddr.size()) begin
			$display("Fail %s: store count expected %0d actual %0d", testName, expStAddr.size(), n);
			testErrors++;
		end
		for (i = 0; i < n && i < expStAddr.size(); i++) begin
			if (stAddrQ[stBase+i] != expStAddr[i] || stDataQ[stBase+i] != expStData[i]) begin
				$display("Fail %s: store %0d expected [%h]=%h actual [%h]=%h", testName, i,
					expStAddr[i], expStData[i], stAddrQ[stBase+i], stDataQ[stBase+i]);
				testErrors++;
			end
		end
	endtask

	task automatic finishTest();
		compareEvents();
		if (strobeInReset != resetErrBase) begin
			$display("Test %s saw a write or store strobe while reset was held", testName);
			testErrors++;
		end
		if (testErrors == 0)
			$display("Test %s passed", testName);
		else begin
			$display("Test %s failed with %0d errors", testName, testErrors);
			failedTests++;
		end
		errorCount += testErrors;
	endtask

	task automatic resetQuietTest();
		int i;
		startTest("reset_quiet");
		for (i = 0; i < 20; i++)
			prog.push_back(nopWord);
		executeProgram();
		finishTest();
	endtask

	task automatic rTypeAluTest();
		logic [31:0] a, b;
		startTest("rtype_alu");
		a = signExtend(randImm());
		b = signExtend(randImm());
		addWritingInstr(iInstr(opAddi, 0, 1, a[15:0]), 1, a);
		addWritingInstr(iInstr(opAddi, 0, 2, b[15:0]), 2, b);
		addWritingInstr(rInstr(fnAdd, 1, 2, 3), 3, a + b);
		addWritingInstr(rInstr(fnAddu, 1, 2, 4), 4, a + b);
		addWritingInstr(rInstr(fnSub, 1, 2, 5), 5, a - b);
		addWritingInstr(rInstr(fnSubu, 2, 1, 6), 6, b - a);
		addWritingInstr(rInstr(fnAnd, 1, 2, 7), 7, a & b);
		addWritingInstr(rInstr(fnOr, 1, 2, 8), 8, a | b);
		addWritingInstr(rInstr(fnXor, 1, 2, 9), 9, a ^ b);
		addWritingInstr(rInstr(fnNor, 1, 2, 10), 10, ~(a | b));
		addWritingInstr(rInstr(fnSlt, 1, 2, 11), 11, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		addWritingInstr(rInstr(fnSlt, 2, 1, 12), 12, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		prog.push_back(rInstr(fnAdd, 1, 2, 0)); // Dropped write to r0
		addWritingInstr(rInstr(fnOr, 0, 0, 13), 13, 32'h0);
		executeProgram();
		finishTest();
	endtask

	task automatic immediateExtendTest();
		logic [15:0] r;
		startTest("imm_extend");
		r = randImm();
		addWritingInstr(iInstr(opAddi, 0, 1, 16'h8001), 1, 32'hFFFF_8001);
		addWritingInstr(iInstr(opAddiu, 0, 2, 16'hF00F), 2, 32'hFFFF_F00F);
		addWritingInstr(iInstr(opOri, 0, 3, 16'h9234), 3, 32'h0000_9234);
		addWritingInstr(iInstr(opAddi, 0, 4, 16'hFFFF), 4, 32'hFFFF_FFFF);
		addWritingInstr(iInstr(opAndi, 4, 5, 16'hC3A5), 5, 32'h0000_C3A5);
		addWritingInstr(iInstr(opOri, 1, 6, r), 6, 32'hFFFF_8001 | {16'h0, r});
		addWritingInstr(iInstr(opAddiu, 3, 7, 16'h7FFF), 7, 32'h0000_9234 + 32'h0000_7FFF);
		addWritingInstr(iInstr(opAndi, 2, 8, r), 8, 32'hFFFF_F00F & {16'h0, r});
		executeProgram();
		finishTest();
	endtask

	task automatic storeLoadTest();
		logic [31:0] v;
		startTest("store_load");
		v = signExtend(randImm());
		addWritingInstr(iInstr(opAddi, 0, 1, v[15:0]), 1, v);
		addWritingInstr(iInstr(opOri, 0, 2, 16'h0040), 2, 32'h40); // Base address
		addStoringInstr(iInstr(opSw, 2, 1, 16'h0008), 32'h48, v);
		addWritingInstr(iInstr(opLw, 2, 3, 16'h0008), 3, v);
		addWritingInstr(rInstr(fnAddu, 3, 3, 4), 4, v + v); // Uses loaded r3
		addStoringInstr(iInstr(opSw, 2, 4, 16'hFFFC), 32'h3C, v + v);
		addWritingInstr(iInstr(opLw, 2, 5, 16'hFFFC), 5, v + v);
		executeProgram();
		finishTest();
	endtask

	task automatic controlFlowTest();
		startTest("control_flow");
		addWritingInstr(iInstr(opAddi, 0, 1, 16'd5), 1, 32'd5);
		addWritingInstr(iInstr(opAddi, 0, 2, 16'd5), 2, 32'd5);
		addWritingInstr(iInstr(opAddi, 0, 3, 16'd7), 3, 32'd7);
		prog.push_back(iInstr(opBeq, 1, 2, 16'd1)); // Taken
		prog.push_back(iInstr(opAddi, 0, 10, 16'd1));
		prog.push_back(iInstr(opBne, 1, 3, 16'd1)); // Taken
		prog.push_back(iInstr(opAddi, 0, 11, 16'd2));
		prog.push_back(iInstr(opBeq, 1, 3, 16'd1)); // Falls through
		addWritingInstr(iInstr(opAddi, 0, 4, 16'd8), 4, 32'd8);
		prog.push_back(iInstr(opBne, 1, 2, 16'd1)); // Falls through
		addWritingInstr(iInstr(opAddi, 0, 5, 16'd9), 5, 32'd9);
		prog.push_back(jInstr(13));
		prog.push_back(iInstr(opAddi, 0, 12, 16'd3));
		addWritingInstr(iInstr(opAddi, 0, 6, 16'd10), 6, 32'd10);
		executeProgram();
		finishTest();
	endtask

	initial begin
		rst = 1'b1;
		imemWriteEn = 1'b0;
		imemAddr = '0;
		imemData = '0;
		resetQuietTest();
		rTypeAluTest();
		immediateExtendTest();
		storeLoadTest();
		controlFlowTest();
		$display("Tests run 5, tests failed %0d, checks failed %0d", failedTests, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: rtl/mipsCore.sv
`timescale 1ns/10ps

module mipsCore #(
	parameter int imemWords = 64,
	parameter int dmemWords = 64
) (
	input  logic                             Clk,
	input  logic                             rst,
	input  logic                             imemWriteEn,
	input  logic [$clog2(imemWords)-1:0]     imemAddr,
	input  logic [mipsPkg::dataWidth-1:0]    imemData,
	output logic                             regWriteEn,
	output logic [mipsPkg::regAddrWidth-1:0] regWriteAddr,
	output logic [mipsPkg::dataWidth-1:0]    regWriteData,
	output logic                             memWriteEn,
	output logic [mipsPkg::dataWidth-1:0]    memAddr,
	output logic [mipsPkg::dataWidth-1:0]    memWriteData
);
	import mipsPkg::*;

	logic stall;
	logic redirect;
	logic [dataWidth-1:0] redirectPc;
	logic [dataWidth-1:0] fetchInstr;
	logic [dataWidth-1:0] fetchNextPc;
	instrT decInstr;
	logic [dataWidth-1:0] decNextPc;

	instructionFetch #(.imemWords(imemWords)) u_fetch (
		.Clk(Clk), .rst(rst), .stall(stall), .redirect(redirect), .redirectPc(redirectPc),
		.imemWriteEn(imemWriteEn), .imemAddr(imemAddr), .imemData(imemData),
		.fetchInstr(fetchInstr), .fetchNextPc(fetchNextPc)
	);

	fetchDecodeReg u_fetchDecodeReg (
		.Clk(Clk), .rst(rst), .flush(redirect), .stall(stall),
		.fetchInstr(fetchInstr), .fetchNextPc(fetchNextPc),
		.decInstr(decInstr), .decNextPc(decNextPc)
	);

	executeStage #(.dmemWords(dmemWords)) u_execute (
		.Clk(Clk), .rst(rst), .decInstr(decInstr), .decNextPc(decNextPc),
		.redirect(redirect), .redirectPc(redirectPc), .stall(stall),
		.regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
		.memWriteEn(memWriteEn), .memAddr(memAddr), .memWriteData(memWriteData)
	);

endmodule

// File: rtl/fetchDecodeReg.sv
`timescale 1ns/10ps

module fetchDecodeReg (
	input  logic                          Clk,
	input  logic                          rst,
	input  logic                          flush,
	input  logic                          stall,
	input  logic [mipsPkg::dataWidth-1:0] fetchInstr,
	input  logic [mipsPkg::dataWidth-1:0] fetchNextPc,
	output mipsPkg::instrT                decInstr,
	output logic [mipsPkg::dataWidth-1:0] decNextPc
);
	import mipsPkg::*;

	always_ff @(posedge Clk) begin
		if (rst || flush) begin
			decInstr <= nopWord; // Bubble
			decNextPc <= '0;
		end else if (!stall) begin
			decInstr <= fetchInstr;
			decNextPc <= fetchNextPc;
		end
	end

	// Redirect and load stall come from the execute stage and must not overlap
	flushStallExclusive: assert property (@(posedge Clk) !(flush && stall));

endmodule

// File: rtl/instructionFetch.sv
`timescale 1ns/10ps

module instructionFetch #(
	parameter int imemWords = 64
) (
	input  logic                          Clk,
	input  logic                          rst,
	input  logic                          stall,
	input  logic                          redirect,
	input  logic [mipsPkg::dataWidth-1:0] redirectPc,
	input  logic                          imemWriteEn,
	input  logic [$clog2(imemWords)-1:0]  imemAddr,
	input  logic [mipsPkg::dataWidth-1:0] imemData,
	output logic [mipsPkg::dataWidth-1:0] fetchInstr,
	output logic [mipsPkg::dataWidth-1:0] fetchNextPc
);
	import mipsPkg::*;

	localparam int indexWidth = $clog2(imemWords);

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] imem [imemWords];

	assign fetchNextPc = pc + dataWidth'(4);
	assign fetchInstr = imem[pc[indexWidth+1:2]]; // Word index

	always_ff @(posedge Clk) begin
		if (rst)
			pc <= '0;
		else if (redirect)
			pc <= redirectPc;
		else if (!stall)
			pc <= fetchNextPc;
	end

	always_ff @(posedge Clk) begin
		if (imemWriteEn)
			imem[imemAddr] <= imemData; // Program load
	end

	// Program may only be written while the core is held in reset
	imemLoadInReset: assert property (@(posedge Clk) imemWriteEn |-> rst);

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/10ps

module executeStage #(
	parameter int dmemWords = 64
) (
	input  logic                             Clk,
	input  logic                             rst,
	input  mipsPkg::instrT                   decInstr,
	input  logic [mipsPkg::dataWidth-1:0]    decNextPc,
	output logic                             redirect,
	output logic [mipsPkg::dataWidth-1:0]    redirectPc,
	output logic                             stall,
	output logic                             regWriteEn,
	output logic [mipsPkg::regAddrWidth-1:0] regWriteAddr,
	output logic [mipsPkg::dataWidth-1:0]    regWriteData,
	output logic                             memWriteEn,
	output logic [mipsPkg::dataWidth-1:0]    memAddr,
	output logic [mipsPkg::dataWidth-1:0]    memWriteData
);
	import mipsPkg::*;

	aluOpT aluOp;
	logic aluSrcImm, immSigned, regDstRd, regWrite;
	logic memRead, memWrite, branchEq, branchNe, jump;
	logic loadPending;
	logic aluZero;
	logic branchTaken;
	logic [dataWidth-1:0] readDataA, readDataB;
	logic [dataWidth-1:0] immExt, operandB, aluResult, memReadData;
	logic [dataWidth-1:0] branchTarget, jumpTarget;

	controlDecoder u_decoder (
		.decInstr(decInstr), .aluOp(aluOp), .aluSrcImm(aluSrcImm), .immSigned(immSigned),
		.regDstRd(regDstRd), .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
		.branchEq(branchEq), .branchNe(branchNe), .jump(jump)
	);

	registerFile u_regFile (
		.Clk(Clk), .rst(rst), .readAddrA(decInstr.rType.rs), .readAddrB(decInstr.rType.rt),
		.writeEn(regWriteEn), .writeAddr(regWriteAddr), .writeData(regWriteData),
		.readDataA(readDataA), .readDataB(readDataB)
	);

	assign immExt = {{(dataWidth-immWidth){immSigned && decInstr.iType.imm[immWidth-1]}},
		decInstr.iType.imm};
	assign operandB = aluSrcImm ? immExt : readDataB;

	alu u_alu (
		.aluOp(aluOp), .operandA(readDataA), .operandB(operandB),
		.result(aluResult), .zero(aluZero)
	);

	dataMemory #(.dmemWords(dmemWords)) u_dataMem (
		.Clk(Clk), .writeEn(memWrite), .readEn(stall), .addr(aluResult),
		.writeData(readDataB), .readData(memReadData)
	);

	// Branch and jump resolution
	assign branchTaken = (branchEq && aluZero) || (branchNe && !aluZero);
	assign branchTarget = decNextPc + {immExt[dataWidth-3:0], 2'b00};
	assign jumpTarget = {decNextPc[dataWidth-1:dataWidth-4], decInstr.rType.rs,
		decInstr.rType.rt, decInstr.rType.rd, decInstr.rType.shamt,
		decInstr.rType.funct, 2'b00};
	assign redirect = branchTaken || jump;
	assign redirectPc = jump ? jumpTarget : branchTarget;

	// Load holds the stage one extra cycle for the memory read
	assign stall = memRead && !loadPending;

	always_ff @(posedge Clk) begin
		if (rst)
			loadPending <= 1'b0;
		else
			loadPending <= stall;
	end

	assign regWriteAddr = regDstRd ? decInstr.rType.rd : decInstr.rType.rt;
	assign regWriteData = memRead ? memReadData : aluResult;
	assign regWriteEn = regWrite && (!memRead || loadPending) && (regWriteAddr != '0);

	assign memWriteEn = memWrite;
	assign memAddr = aluResult;
	assign memWriteData = readDataB;

endmodule

// File: rtl/dataMemory.sv
`timescale 1ns/10ps

module dataMemory #(
	parameter int dmemWords = 64
) (
	input  logic                          Clk,
	input  logic                          writeEn,
	input  logic                          readEn,
	input  logic [mipsPkg::dataWidth-1:0] addr,
	input  logic [mipsPkg::dataWidth-1:0] writeData,
	output logic [mipsPkg::dataWidth-1:0] readData
);
	import mipsPkg::*;

	localparam int indexWidth = $clog2(dmemWords);

	logic [dataWidth-1:0] mem [dmemWords];
	logic [indexWidth-1:0] index;

	assign index = addr[indexWidth+1:2]; // Byte to word address

	always_ff @(posedge Clk) begin
		if (writeEn)
			mem[index] <= writeData;
		if (readEn)
			readData <= mem[index];
	end

	// Only whole words are supported
	wordAligned: assert property (@(posedge Clk) (readEn || writeEn) |-> (addr[1:0] == 2'b00));

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/10ps

module registerFile (
	input  logic                             Clk,
	input  logic                             rst,
	input  logic [mipsPkg::regAddrWidth-1:0] readAddrA,
	input  logic [mipsPkg::regAddrWidth-1:0] readAddrB,
	input  logic                             writeEn,
	input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
	input  logic [mipsPkg::dataWidth-1:0]    writeData,
	output logic [mipsPkg::dataWidth-1:0]    readDataA,
	output logic [mipsPkg::dataWidth-1:0]    readDataB
);
	import mipsPkg::*;

	localparam int numRegs = 2 ** regAddrWidth;

	logic [dataWidth-1:0] regs [numRegs];

	// r0 is hardwired
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (writeEn && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

// File: rtl/controlDecoder.sv
`timescale 1ns/10ps

module controlDecoder (
	input  mipsPkg::instrT decInstr,
	output mipsPkg::aluOpT aluOp,
	output logic           aluSrcImm,
	output logic           immSigned,
	output logic           regDstRd,
	output logic           regWrite,
	output logic           memRead,
	output logic           memWrite,
	output logic           branchEq,
	output logic           branchNe,
	output logic           jump
);
	import mipsPkg::*;

	always_comb begin
		aluOp = aluAnd;
		aluSrcImm = 1'b0;
		immSigned = 1'b0;
		regDstRd = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		case (decInstr.rType.op)
			opRType: begin
				regDstRd = 1'b1;
				regWrite = 1'b1;
				case (decInstr.rType.funct)
					fnAdd, fnAddu: aluOp = aluAdd;
					fnSub, fnSubu: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnNor: aluOp = aluNor;
					fnSlt: aluOp = aluSlt;
					default: begin // Includes the all-zero no-op
						regDstRd = 1'b0;
						regWrite = 1'b0;
					end
				endcase
			end
			opAddi, opAddiu: begin
				aluOp = aluAdd;
				aluSrcImm = 1'b1;
				immSigned = 1'b1;
				regWrite = 1'b1;
			end
			opAndi: begin
				aluOp = aluAnd;
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
			end
			opOri: begin
				aluOp = aluOr;
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
			end
			opLw: begin
				aluOp = aluAdd;
				aluSrcImm = 1'b1;
				immSigned = 1'b1;
				regWrite = 1'b1;
				memRead = 1'b1;
			end
			opSw: begin
				aluOp = aluAdd;
				aluSrcImm = 1'b1;
				immSigned = 1'b1;
				memWrite = 1'b1;
			end
			opBeq, opBne: begin
				aluOp = aluSub; // Compare via zero flag
				immSigned = 1'b1; // Signed branch offset
				branchEq = (decInstr.iType.op == opBeq);
				branchNe = (decInstr.iType.op == opBne);
			end
			opJ: jump = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: rtl/alu.sv
`timescale 1ns/10ps

module alu (
	input  mipsPkg::aluOpT                aluOp,
	input  logic [mipsPkg::dataWidth-1:0] operandA,
	input  logic [mipsPkg::dataWidth-1:0] operandB,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic                          zero
);
	import mipsPkg::*;

	logic lessThan;

	assign lessThan = ($signed(operandA) < $signed(operandB)); // Signed SLT

	always_comb begin
		case (aluOp)
			aluAnd: result = operandA & operandB;
			aluOr: result = operandA | operandB;
			aluAdd: result = operandA + operandB;
			aluXor: result = operandA ^ operandB;
			aluNor: result = ~(operandA | operandB);
			aluSub: result = operandA - operandB;
			aluSlt: result = {{(dataWidth-1){1'b0}}, lessThan};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // Drives BEQ/BNE

endmodule

// File: rtl/mipsPkg.sv
package mipsPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int opWidth = 6;
	localparam int immWidth = 16;

	// Primary opcodes
	localparam logic [opWidth-1:0] opRType = 6'd0;
	localparam logic [opWidth-1:0] opJ = 6'd2;
	localparam logic [opWidth-1:0] opBeq = 6'd4;
	localparam logic [opWidth-1:0] opBne = 6'd5;
	localparam logic [opWidth-1:0] opAddi = 6'd8;
	localparam logic [opWidth-1:0] opAddiu = 6'd9;
	localparam logic [opWidth-1:0] opAndi = 6'd12;
	localparam logic [opWidth-1:0] opOri = 6'd13;
	localparam logic [opWidth-1:0] opLw = 6'd35;
	localparam logic [opWidth-1:0] opSw = 6'd43;

	// Function codes under opRType
	localparam logic [5:0] fnAdd = 6'd32;
	localparam logic [5:0] fnAddu = 6'd33;
	localparam logic [5:0] fnSub = 6'd34;
	localparam logic [5:0] fnSubu = 6'd35;
	localparam logic [5:0] fnAnd = 6'd36;
	localparam logic [5:0] fnOr = 6'd37;
	localparam logic [5:0] fnXor = 6'd38;
	localparam logic [5:0] fnNor = 6'd39;
	localparam logic [5:0] fnSlt = 6'd42;

	typedef enum logic [3:0] {
		aluAnd = 4'd0,
		aluOr  = 4'd1,
		aluAdd = 4'd2,
		aluNor = 4'd3,
		aluXor = 4'd4,
		aluSub = 4'd6,
		aluSlt = 4'd7
	} aluOpT;

	typedef struct packed {
		logic [opWidth-1:0]      op;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [4:0]              shamt;
		logic [5:0]              funct;
	} rTypeT;

	typedef struct packed {
		logic [opWidth-1:0]      op;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [immWidth-1:0]     imm;
	} iTypeT;

	typedef union packed {
		rTypeT rType;
		iTypeT iType;
	} instrT;

	localparam instrT nopWord = '0;

endpackage
